/* Bender.yml */
package:
  name: core

sources:
  - hw/core_pkg.sv
  - hw/fetch.sv
  - hw/reg_file.sv
  - hw/decode.sv
  - hw/execute.sv
  - hw/writeback.sv
  - hw/core_top.sv
  - target: simulation
    files:
      - testbench/core_tb.sv

/* hw/core_pkg.sv */
package core_pkg;

    localparam int REG_NUM = 32;

    typedef logic [4:0] reg_idx_t;
    typedef logic [31:0] u32_t;

    localparam u32_t RESET_PC = 32'h0000_0000;

    // LoongArch-32 major opcodes, one field width per format
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT = 17'h00024;
    localparam logic [16:0] OPC_AND = 17'h00029;
    localparam logic [16:0] OPC_OR = 17'h0002a;
    localparam logic [16:0] OPC_XOR = 17'h0002b;
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI = 10'h00d;
    localparam logic [9:0] OPC_ORI = 10'h00e;
    localparam logic [5:0] OPC_BEQ = 6'h16;
    localparam logic [5:0] OPC_BNE = 6'h17;

    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t rk;
        reg_idx_t rj;
        reg_idx_t rd;
    } r3_t;

    typedef struct packed {
        logic [9:0] opcode;
        logic [11:0] imm;
        reg_idx_t rj;
        reg_idx_t rd;
    } ri12_t;

    // Branch offset is in words
    typedef struct packed {
        logic [5:0] opcode;
        logic [15:0] offs;
        reg_idx_t rj;
        reg_idx_t rd;
    } i16_t;

    typedef union packed {
        r3_t r3;
        ri12_t ri12;
        i16_t i16;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_BEQ,
        ALU_BNE,
        ALU_NOP
    } alu_op_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        instr_u instr;
    } fetch_decode_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        alu_op_t alu_op;
        u32_t operand_a;
        u32_t operand_b;
        reg_idx_t rd;
        logic reg_we;
        u32_t branch_target;
    } decode_execute_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        reg_idx_t rd;
        logic reg_we;
        u32_t result;
    } execute_writeback_t;

    typedef struct packed {
        logic valid;
        u32_t target;
    } wr_pc_req_t;

    typedef struct packed {
        u32_t pc;
        reg_idx_t rd;
        logic reg_we;
        u32_t data;
    } retire_t;

endpackage

/* hw/core_top.sv */
`timescale 1ns/100ps

module core_top (
    input logic clk,
    input logic reset,
    output logic imem_req,
    output core_pkg::u32_t imem_addr,
    input logic imem_ack,
    input core_pkg::instr_u imem_data,
    output logic retire_valid,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    fetch_decode_t fetch_decode;
    decode_execute_t decode_execute;
    execute_writeback_t execute_writeback;
    execute_writeback_t ex_fwd;
    execute_writeback_t wb_fwd;
    wr_pc_req_t wr_pc_req;
    logic flush;

    reg_idx_t rj_idx;
    reg_idx_t rk_idx;
    reg_idx_t wr_idx;
    u32_t rj_data;
    u32_t rk_data;
    u32_t wr_data;
    logic reg_we;

    fetch fetch_i (
        .clk,
        .reset,
        .imem_req,
        .imem_addr,
        .imem_ack,
        .imem_data,
        .wr_pc_req,
        .flush,
        .fetch_out(fetch_decode)
    );

    decode decode_i (
        .clk,
        .reset,
        .fetch_in(fetch_decode),
        .flush,
        .rj_idx,
        .rk_idx,
        .rj_data,
        .rk_data,
        .ex_fwd,
        .wb_fwd,
        .decode_out(decode_execute)
    );

    execute execute_i (
        .clk,
        .reset,
        .decode_in(decode_execute),
        .flush,
        .wr_pc_req,
        .ex_fwd,
        .execute_out(execute_writeback)
    );

    writeback writeback_i (
        .execute_in(execute_writeback),
        .we(reg_we),
        .wr_idx,
        .wr_data,
        .wb_fwd,
        .retire_valid,
        .retire
    );

    reg_file reg_file_i (
        .clk,
        .reset,
        .rj_idx,
        .rk_idx,
        .rj_data,
        .rk_data,
        .we(reg_we),
        .wr_idx,
        .wr_data
    );

endmodule

/* hw/decode.sv */
`timescale 1ns/100ps

module decode (
    input logic clk,
    input logic reset,
    input core_pkg::fetch_decode_t fetch_in,
    input logic flush,
    output core_pkg::reg_idx_t rj_idx,
    output core_pkg::reg_idx_t rk_idx,
    input core_pkg::u32_t rj_data,
    input core_pkg::u32_t rk_data,
    input core_pkg::execute_writeback_t ex_fwd,
    input core_pkg::execute_writeback_t wb_fwd,
    output core_pkg::decode_execute_t decode_out
);
    import core_pkg::*;

    instr_u instr;
    alu_op_t op;
    logic use_imm;
    logic is_branch;
    u32_t imm;
    u32_t br_offs;
    u32_t rj_val;
    u32_t rk_val;

    // Younger producer wins over older and over the register file
    function automatic u32_t pick_operand(
        input reg_idx_t idx,
        input u32_t rf_val,
        input execute_writeback_t ex,
        input execute_writeback_t wb
    );
        if (ex.valid && ex.reg_we && ex.rd == idx)
            return ex.result;
        if (wb.valid && wb.reg_we && wb.rd == idx)
            return wb.result;
        return rf_val;
    endfunction

    assign instr = fetch_in.instr;

    always_comb begin
        op = ALU_NOP;
        use_imm = 1'b0;
        imm = '0;
        case (instr.r3.opcode)
            OPC_ADD_W: op = ALU_ADD;
            OPC_SUB_W: op = ALU_SUB;
            OPC_SLT: op = ALU_SLT;
            OPC_AND: op = ALU_AND;
            OPC_OR: op = ALU_OR;
            OPC_XOR: op = ALU_XOR;
            default: ;
        endcase
        case (instr.ri12.opcode)
            OPC_ADDI_W: begin
                op = ALU_ADD;
                use_imm = 1'b1;
                imm = {{20{instr.ri12.imm[11]}}, instr.ri12.imm};
            end
            OPC_ANDI: begin
                op = ALU_AND;
                use_imm = 1'b1;
                imm = {20'b0, instr.ri12.imm};
            end
            OPC_ORI: begin
                op = ALU_OR;
                use_imm = 1'b1;
                imm = {20'b0, instr.ri12.imm};
            end
            default: ;
        endcase
        case (instr.i16.opcode)
            OPC_BEQ: op = ALU_BEQ;
            OPC_BNE: op = ALU_BNE;
            default: ;
        endcase
    end

    assign is_branch = (op == ALU_BEQ) || (op == ALU_BNE);
    assign br_offs = {{14{instr.i16.offs[15]}}, instr.i16.offs, 2'b00};

    // Branches compare rj against rd
    assign rj_idx = instr.r3.rj;
    assign rk_idx = is_branch ? instr.i16.rd : instr.r3.rk;

    assign rj_val = pick_operand(rj_idx, rj_data, ex_fwd, wb_fwd);
    assign rk_val = pick_operand(rk_idx, rk_data, ex_fwd, wb_fwd);

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_out.valid <= 1'b0;
        end else begin
            decode_out.valid <= fetch_in.valid && !flush;
            decode_out.pc <= fetch_in.pc;
            decode_out.alu_op <= op;
            decode_out.operand_a <= rj_val;
            decode_out.operand_b <= use_imm ? imm : rk_val;
            decode_out.rd <= instr.r3.rd;
            decode_out.reg_we <= !is_branch && (op != ALU_NOP);
            decode_out.branch_target <= fetch_in.pc + br_offs;
        end
    end

    // Fetch only ever hands over word-aligned addresses
    assert property (@(posedge clk) disable iff (reset)
        fetch_in.valid |-> (fetch_in.pc[1:0] == 2'b00));

endmodule

/* hw/execute.sv */
`timescale 1ns/100ps

module execute (
    input logic clk,
    input logic reset,
    input core_pkg::decode_execute_t decode_in,
    output logic flush,
    output core_pkg::wr_pc_req_t wr_pc_req,
    output core_pkg::execute_writeback_t ex_fwd,
    output core_pkg::execute_writeback_t execute_out
);
    import core_pkg::*;

    u32_t a;
    u32_t b;
    u32_t result;
    logic equal;
    logic less;
    logic taken;

    assign a = decode_in.operand_a;
    assign b = decode_in.operand_b;
    assign equal = (a == b);
    assign less = $signed(a) < $signed(b);

    always_comb begin
        result = '0;
        taken = 1'b0;
        case (decode_in.alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLT: result = {31'b0, less};
            ALU_AND: result = a & b;
            ALU_OR: result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_BEQ: taken = equal;
            ALU_BNE: taken = !equal;
            default: ;
        endcase
    end

    assign flush = decode_in.valid && taken;
    assign wr_pc_req.valid = flush;
    assign wr_pc_req.target = decode_in.branch_target;

    // Writes to r0 are not offered for forwarding
    assign ex_fwd.valid = decode_in.valid;
    assign ex_fwd.pc = decode_in.pc;
    assign ex_fwd.rd = decode_in.rd;
    assign ex_fwd.reg_we = decode_in.reg_we && (decode_in.rd != '0);
    assign ex_fwd.result = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            execute_out.valid <= 1'b0;
        end else begin
            execute_out.valid <= decode_in.valid;
            execute_out.pc <= decode_in.pc;
            execute_out.rd <= decode_in.rd;
            execute_out.reg_we <= decode_in.reg_we;
            execute_out.result <= result;
        end
    end

    // Taken branch kills the younger word in decode
    assert property (@(posedge clk) disable iff (reset)
        flush |=> !decode_in.valid);

endmodule

/* hw/fetch.sv */
`timescale 1ns/100ps

module fetch (
    input logic clk,
    input logic reset,
    output logic imem_req,
    output core_pkg::u32_t imem_addr,
    input logic imem_ack,
    input core_pkg::instr_u imem_data,
    input core_pkg::wr_pc_req_t wr_pc_req,
    input logic flush,
    output core_pkg::fetch_decode_t fetch_out
);
    import core_pkg::*;

    typedef enum logic {
        S_WAIT,
        S_REQ
    } state_t;

    state_t state;
    u32_t pc;
    u32_t next_pc;
    logic discard;
    logic capture;

    // Word arrives and still belongs to the program path
    assign capture = (state == S_REQ) && imem_ack && !discard && !flush;

    always_comb begin
        if (wr_pc_req.valid)
            next_pc = wr_pc_req.target;
        else if (capture)
            next_pc = pc + 32'd4;
        else
            next_pc = pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_WAIT;
            pc <= RESET_PC;
            discard <= 1'b0;
            fetch_out.valid <= 1'b0;
        end else begin
            pc <= next_pc;
            fetch_out.valid <= capture;
            if (capture) begin
                fetch_out.pc <= imem_addr;
                fetch_out.instr <= imem_data;
            end
            case (state)
                S_WAIT: begin
                    // Ack must return low before the next request
                    if (!imem_ack) begin
                        state <= S_REQ;
                        imem_addr <= next_pc;
                    end
                end
                S_REQ: begin
                    if (imem_ack) begin
                        state <= S_WAIT;
                        discard <= 1'b0;
                    end else if (flush) begin
                        // Let the handshake finish, drop the word later
                        discard <= 1'b1;
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    assign imem_req = (state == S_REQ);

    assert property (@(posedge clk) disable iff (reset) $rose(imem_req) |-> !imem_ack);

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input logic clk,
    input logic reset,
    input core_pkg::reg_idx_t rj_idx,
    input core_pkg::reg_idx_t rk_idx,
    output core_pkg::u32_t rj_data,
    output core_pkg::u32_t rk_data,
    input logic we,
    input core_pkg::reg_idx_t wr_idx,
    input core_pkg::u32_t wr_data
);
    import core_pkg::*;

    u32_t regs [REG_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // r0 is never written
    assign rj_data = regs[rj_idx];
    assign rk_data = regs[rk_idx];

endmodule

/* hw/writeback.sv */
`timescale 1ns/100ps

module writeback (
    input core_pkg::execute_writeback_t execute_in,
    output logic we,
    output core_pkg::reg_idx_t wr_idx,
    output core_pkg::u32_t wr_data,
    output core_pkg::execute_writeback_t wb_fwd,
    output logic retire_valid,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    assign we = execute_in.valid && execute_in.reg_we;
    assign wr_idx = execute_in.rd;
    assign wr_data = execute_in.result;

    // Pending write, visible to decode until the register file takes it
    assign wb_fwd.valid = execute_in.valid;
    assign wb_fwd.pc = execute_in.pc;
    assign wb_fwd.rd = execute_in.rd;
    assign wb_fwd.reg_we = we && (execute_in.rd != '0);
    assign wb_fwd.result = execute_in.result;

    assign retire_valid = execute_in.valid;

    always_comb begin
        retire = '0;
        retire.pc = execute_in.pc;
        retire.rd = execute_in.rd;
        retire.reg_we = execute_in.reg_we;
        retire.data = execute_in.result;
    end

endmodule

/* sim.f */
hw/core_pkg.sv
hw/fetch.sv
hw/reg_file.sv
hw/decode.sv
hw/execute.sv
hw/writeback.sv
hw/core_top.sv
testbench/core_tb.sv

/* testbench/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
    import core_pkg::*;

    localparam int PROG_LEN = 200;
    localparam u32_t PROG_BYTES = PROG_LEN * 4;
    localparam int DELAY_NUM = 512;
    localparam int ZERO_DELAY_NUM = 40;
    localparam int WATCHDOG_NS = (PROG_LEN * 10 + 4) * 8;

    logic clk = 1'b0;
    logic reset;
    logic imem_req;
    u32_t imem_addr;
    logic imem_ack;
    instr_u imem_data;
    logic retire_valid;
    retire_t retire;

    instr_u prog [PROG_LEN];
    int ack_delay [DELAY_NUM];
    u32_t model_regs [REG_NUM];
    u32_t model_pc;
    int n_checked = 0;
    int n_errors = 0;
    logic done = 1'b0;

    core_top core_top_i (
        .clk,
        .reset,
        .imem_req,
        .imem_addr,
        .imem_ack,
        .imem_data,
        .retire_valid,
        .retire
    );

    always #4 clk = ~clk;

    // Past the program every address holds ADDI.W r0, r0, 0
    function automatic instr_u fetch_word(input u32_t addr);
        if (addr < PROG_BYTES)
            return prog[addr[31:2]];
        return {OPC_ADDI_W, 12'h000, 5'd0, 5'd0};
    endfunction

    function automatic instr_u gen_word();
        instr_u w;
        int kind;
        int sel;
        kind = $urandom_range(99, 0);
        sel = $urandom_range(5, 0);
        w = instr_u'($urandom);
        if (kind < 15) begin
            w.i16.opcode = sel[0] ? OPC_BNE : OPC_BEQ;
            w.i16.offs = 16'($urandom_range(4, 1));
            w.i16.rj = 5'($urandom_range(7, 0));
            w.i16.rd = 5'($urandom_range(7, 0));
        end else if (kind < 18) begin
            // No format claims this opcode
            w.i16.opcode = 6'h3f;
        end else if (kind < 60) begin
            case (sel % 3)
                0: w.ri12.opcode = OPC_ADDI_W;
                1: w.ri12.opcode = OPC_ANDI;
                default: w.ri12.opcode = OPC_ORI;
            endcase
            w.ri12.rj = 5'($urandom_range(7, 0));
            w.ri12.rd = 5'($urandom_range(7, 0));
        end else begin
            case (sel)
                0: w.r3.opcode = OPC_ADD_W;
                1: w.r3.opcode = OPC_SUB_W;
                2: w.r3.opcode = OPC_SLT;
                3: w.r3.opcode = OPC_AND;
                4: w.r3.opcode = OPC_OR;
                default: w.r3.opcode = OPC_XOR;
            endcase
            w.r3.rk = 5'($urandom_range(7, 0));
            w.r3.rj = 5'($urandom_range(7, 0));
            w.r3.rd = 5'($urandom_range(7, 0));
        end
        return w;
    endfunction

    // One instruction on the model register file
    function automatic retire_t ref_step(input u32_t pc, output u32_t next_pc);
        instr_u w;
        retire_t r;
        u32_t a;
        u32_t b;
        u32_t imm;
        w = fetch_word(pc);
        r.pc = pc;
        r.rd = w.r3.rd;
        r.reg_we = 1'b0;
        r.data = '0;
        next_pc = pc + 32'd4;
        a = model_regs[w.r3.rj];
        if (w.i16.opcode == OPC_BEQ || w.i16.opcode == OPC_BNE) begin
            b = model_regs[w.i16.rd];
            if ((a == b) == (w.i16.opcode == OPC_BEQ))
                next_pc = pc + ({{16{w.i16.offs[15]}}, w.i16.offs} << 2);
        end else if (w.ri12.opcode inside {OPC_ADDI_W, OPC_ANDI, OPC_ORI}) begin
            r.reg_we = 1'b1;
            if (w.ri12.opcode == OPC_ADDI_W)
                imm = {{20{w.ri12.imm[11]}}, w.ri12.imm};
            else
                imm = {20'b0, w.ri12.imm};
            case (w.ri12.opcode)
                OPC_ADDI_W: r.data = a + imm;
                OPC_ANDI: r.data = a & imm;
                default: r.data = a | imm;
            endcase
        end else if (w.r3.opcode inside {OPC_ADD_W, OPC_SUB_W, OPC_SLT,
                                         OPC_AND, OPC_OR, OPC_XOR}) begin
            r.reg_we = 1'b1;
            b = model_regs[w.r3.rk];
            case (w.r3.opcode)
                OPC_ADD_W: r.data = a + b;
                OPC_SUB_W: r.data = a - b;
                OPC_SLT: r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OPC_AND: r.data = a & b;
                OPC_OR: r.data = a | b;
                default: r.data = a ^ b;
            endcase
        end
        if (r.reg_we && r.rd != 5'd0)
            model_regs[r.rd] = r.data;
        return r;
    endfunction

    task automatic check_pc(input u32_t exp, input u32_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t retire.pc expected %h actual %h", $time, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        if (act.reg_we !== exp.reg_we) begin
            $display("[FAIL] %0t retire.reg_we expected %b actual %b",
                     $time, exp.reg_we, act.reg_we);
            n_errors++;
        end
        if (act.rd !== exp.rd) begin
            $display("[FAIL] %0t retire.rd expected %0d actual %0d", $time, exp.rd, act.rd);
            n_errors++;
        end
        // Data only means something for a write
        if (exp.reg_we && act.data !== exp.data) begin
            $display("[FAIL] %0t retire.data expected %h actual %h",
                     $time, exp.data, act.data);
            n_errors++;
        end
    endtask

    // Instruction source, four-phase handshake
    initial begin
        int n;
        n = 0;
        imem_ack = 1'b0;
        imem_data = '0;
        forever begin
            @(posedge clk);
            if (!reset && imem_req && !imem_ack) begin
                repeat (ack_delay[n % DELAY_NUM]) @(posedge clk);
                n++;
                imem_data <= fetch_word(imem_addr);
                imem_ack <= 1'b1;
                do @(posedge clk); while (imem_req);
                imem_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        retire_t exp;
        u32_t next_pc;
        if (!reset && retire_valid && !done) begin
            exp = ref_step(model_pc, next_pc);
            check_pc(exp.pc, retire.pc);
            check_retire(exp, retire);
            model_pc = next_pc;
            n_checked++;
            if (model_pc >= PROG_BYTES)
                done = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, retirement stalled after %0d instructions", n_checked);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(99));
        reset = 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = gen_word();
        end
        // Early part of the run gets zero-delay acks
        for (int i = 0; i < DELAY_NUM; i++) begin
            ack_delay[i] = (i < ZERO_DELAY_NUM) ? 0 : $urandom_range(3, 0);
        end
        for (int i = 0; i < REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_PC;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        wait (done);
        @(posedge clk);
        $display("Retired %0d instructions with %0d errors", n_checked, n_errors);
        if (n_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
